// ==== rtl/mips_pkg.sv ====
`default_nettype none

package mips_pkg;

    localparam logic [31:0] reset_vector = 32'hBFC00000;
    localparam logic [31:0] halt_address = 32'h00000000;

    // Primary opcodes, bits 31:26
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_J       = 6'h02,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0A,
        OP_SLTIU   = 6'h0B,
        OP_ANDI    = 6'h0C,
        OP_ORI     = 6'h0D,
        OP_XORI    = 6'h0E,
        OP_LUI     = 6'h0F,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2B
    } opcode_e;

    // SPECIAL function field, bits 5:0
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_JR   = 6'h08,
        FN_JALR = 6'h09,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_SLT  = 6'h2A,
        FN_SLTU = 6'h2B
    } funct_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_LUI
    } alu_op_e;

    typedef enum logic {
        IMM_SIGN,
        IMM_ZERO
    } imm_ext_e;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_LINK
    } wb_src_e;

    typedef enum logic [1:0] {
        PC_SEQ,
        PC_BRANCH,
        PC_JUMP,
        PC_REG
    } pc_src_e;

    typedef struct packed {
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  wr_idx;
        logic [4:0]  shamt;
        logic [31:0] imm_ext;
        logic [25:0] jump_index;
        alu_op_e     alu_op;
        logic        alu_src_imm;
        wb_src_e     wb_src;
        pc_src_e     pc_src;
        logic        reg_write;
        logic        mem_read;
        logic        mem_write;
        logic        branch_ne;
    } decoded_t;

    typedef struct packed {
        logic [31:0] alu_result;
        logic        branch_taken;
        logic [31:0] store_data;
    } exec_t;

endpackage

`default_nettype wire

// ==== rtl/mips_decode.sv ====
`timescale 1ns/10ps
`default_nettype none

module mips_decode (
    input  logic [31:0]        instr_readdata,
    input  logic               active,
    output mips_pkg::decoded_t dec
);
    import mips_pkg::*;

    opcode_e     opcode;
    funct_e      funct;
    imm_ext_e    ext_mode;
    logic [15:0] imm16;

    assign opcode = opcode_e'(instr_readdata[31:26]);
    assign funct  = funct_e'(instr_readdata[5:0]);
    assign imm16  = instr_readdata[15:0];

    always_comb begin
        ext_mode        = IMM_SIGN;
        dec             = '0;
        dec.rs          = instr_readdata[25:21];
        dec.rt          = instr_readdata[20:16];
        dec.wr_idx      = instr_readdata[20:16];
        dec.shamt       = instr_readdata[10:6];
        dec.jump_index  = instr_readdata[25:0];
        dec.alu_op      = ALU_ADD;
        dec.wb_src      = WB_ALU;
        dec.pc_src      = PC_SEQ;

        case (opcode)
            OP_SPECIAL: begin
                dec.wr_idx    = instr_readdata[15:11];
                dec.reg_write = 1'b1;
                case (funct)
                    FN_SLL:  dec.alu_op = ALU_SLL;
                    FN_SRL:  dec.alu_op = ALU_SRL;
                    FN_ADDU: dec.alu_op = ALU_ADD;
                    FN_SUBU: dec.alu_op = ALU_SUB;
                    FN_AND:  dec.alu_op = ALU_AND;
                    FN_OR:   dec.alu_op = ALU_OR;
                    FN_XOR:  dec.alu_op = ALU_XOR;
                    FN_SLT:  dec.alu_op = ALU_SLT;
                    FN_SLTU: dec.alu_op = ALU_SLTU;
                    FN_JR: begin
                        dec.pc_src    = PC_REG;
                        dec.reg_write = 1'b0;
                    end
                    FN_JALR: begin
                        dec.pc_src = PC_REG;
                        dec.wb_src = WB_LINK;
                    end
                    // Unknown function code, no-op
                    default: dec.reg_write = 1'b0;
                endcase
            end
            OP_J: dec.pc_src = PC_JUMP;
            OP_JAL: begin
                dec.pc_src    = PC_JUMP;
                dec.wb_src    = WB_LINK;
                dec.wr_idx    = 5'd31;
                dec.reg_write = 1'b1;
            end
            OP_BEQ: dec.pc_src = PC_BRANCH;
            OP_BNE: begin
                dec.pc_src    = PC_BRANCH;
                dec.branch_ne = 1'b1;
            end
            OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                dec.alu_src_imm = 1'b1;
                dec.reg_write   = 1'b1;
                case (opcode)
                    OP_SLTI:  dec.alu_op = ALU_SLT;
                    OP_SLTIU: dec.alu_op = ALU_SLTU;
                    OP_LUI:   dec.alu_op = ALU_LUI;
                    OP_ANDI: begin
                        dec.alu_op = ALU_AND;
                        ext_mode   = IMM_ZERO;
                    end
                    OP_ORI: begin
                        dec.alu_op = ALU_OR;
                        ext_mode   = IMM_ZERO;
                    end
                    OP_XORI: begin
                        dec.alu_op = ALU_XOR;
                        ext_mode   = IMM_ZERO;
                    end
                    default: dec.alu_op = ALU_ADD;
                endcase
            end
            OP_LW: begin
                dec.alu_src_imm = 1'b1;
                dec.mem_read    = 1'b1;
                dec.wb_src      = WB_MEM;
                dec.reg_write   = 1'b1;
            end
            OP_SW: begin
                dec.alu_src_imm = 1'b1;
                dec.mem_write   = 1'b1;
            end
            default: ;
        endcase

        dec.imm_ext = (ext_mode == IMM_ZERO) ? {16'h0000, imm16} : {{16{imm16[15]}}, imm16};

        // No side effects once halted
        if (!active) begin
            dec.reg_write = 1'b0;
            dec.mem_read  = 1'b0;
            dec.mem_write = 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/mips_regfile.sv ====
`timescale 1ns/10ps
`default_nettype none

module mips_regfile (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        write_enable,
    input  logic [4:0]  write_idx,
    input  logic [31:0] write_data,
    input  logic [4:0]  read_idx_a,
    input  logic [4:0]  read_idx_b,
    output logic [31:0] read_data_a,
    output logic [31:0] read_data_b,
    output logic [31:0] register_v0
);

    // Register 0 has no storage
    logic [31:0] regs [1:31];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= 32'h0;
            end
        end else if (write_enable && (write_idx != 5'd0)) begin
            regs[write_idx] <= write_data;
        end
    end

    assign read_data_a = (read_idx_a == 5'd0) ? 32'h0 : regs[read_idx_a];
    assign read_data_b = (read_idx_b == 5'd0) ? 32'h0 : regs[read_idx_b];

    assign register_v0 = regs[2];

endmodule

`default_nettype wire

// ==== rtl/mips_execute.sv ====
`timescale 1ns/10ps
`default_nettype none

module mips_execute (
    input  mips_pkg::decoded_t dec,
    input  logic [31:0]        rs_data,
    input  logic [31:0]        rt_data,
    output mips_pkg::exec_t    exec
);
    import mips_pkg::*;

    logic [31:0] op_b;
    logic [31:0] result;
    logic        regs_equal;

    assign op_b = dec.alu_src_imm ? dec.imm_ext : rt_data;

    always_comb begin
        case (dec.alu_op)
            ALU_ADD:  result = rs_data + op_b;
            ALU_SUB:  result = rs_data - op_b;
            ALU_AND:  result = rs_data & op_b;
            ALU_OR:   result = rs_data | op_b;
            ALU_XOR:  result = rs_data ^ op_b;
            ALU_SLT:  result = {31'h0, $signed(rs_data) < $signed(op_b)};
            ALU_SLTU: result = {31'h0, rs_data < op_b};
            // Shifts operate on rt by shamt
            ALU_SLL:  result = op_b << dec.shamt;
            ALU_SRL:  result = op_b >> dec.shamt;
            ALU_LUI:  result = {op_b[15:0], 16'h0000};
            default:  result = 32'h0;
        endcase
    end

    // BEQ/BNE compare the register operands directly
    assign regs_equal = (rs_data == rt_data);

    assign exec.alu_result   = result;
    assign exec.branch_taken = (dec.pc_src == PC_BRANCH) && (regs_equal ^ dec.branch_ne);
    assign exec.store_data   = rt_data;

endmodule

`default_nettype wire

// ==== rtl/mips_result.sv ====
`timescale 1ns/10ps
`default_nettype none

module mips_result (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               clk_enable,
    input  mips_pkg::decoded_t dec,
    input  mips_pkg::exec_t    exec,
    input  logic [31:0]        mem_data,
    input  logic [31:0]        rs_data,
    output logic [31:0]        pc,
    output logic               active,
    output logic               reg_write_enable,
    output logic [4:0]         reg_write_idx,
    output logic [31:0]        reg_write_data
);
    import mips_pkg::*;

    logic [31:0] pc_plus4;
    logic [31:0] branch_target;
    logic [31:0] jump_target;
    logic [31:0] next_pc;
    logic        update;

    assign update = clk_enable && active;

    assign pc_plus4      = pc + 32'd4;
    assign branch_target = pc_plus4 + {dec.imm_ext[29:0], 2'b00};
    assign jump_target   = {pc_plus4[31:28], dec.jump_index, 2'b00};

    always_comb begin
        case (dec.pc_src)
            PC_BRANCH: next_pc = exec.branch_taken ? branch_target : pc_plus4;
            PC_JUMP:   next_pc = jump_target;
            PC_REG:    next_pc = rs_data;
            default:   next_pc = pc_plus4;
        endcase
    end

    // Write-back
    always_comb begin
        case (dec.wb_src)
            WB_MEM:  reg_write_data = mem_data;
            WB_LINK: reg_write_data = pc_plus4;
            default: reg_write_data = exec.alu_result;
        endcase
    end

    assign reg_write_idx    = dec.wr_idx;
    assign reg_write_enable = update && dec.reg_write;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc     <= reset_vector;
            active <= 1'b1;
        end else if (update) begin
            pc <= next_pc;
            // Jump to the halt address retires, then the core stops
            if (next_pc == halt_address) begin
                active <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/mips_cpu_harvard.sv ====
`timescale 1ns/10ps
`default_nettype none

module mips_cpu_harvard (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        clk_enable,
    output logic        active,
    output logic [31:0] register_v0,

    // Instruction port, combinational read
    output logic [31:0] instr_address,
    input  logic [31:0] instr_readdata,

    // Data port, combinational read and single-cycle write
    output logic [31:0] data_address,
    output logic        data_write,
    output logic        data_read,
    output logic [31:0] data_writedata,
    input  logic [31:0] data_readdata
);
    import mips_pkg::*;

    decoded_t    dec;
    exec_t       exec;
    logic [31:0] rs_data;
    logic [31:0] rt_data;
    logic        reg_write_enable;
    logic [4:0]  reg_write_idx;
    logic [31:0] reg_write_data;

    mips_decode decode_i (
        .instr_readdata (instr_readdata),
        .active         (active),
        .dec            (dec)
    );

    mips_regfile regfile_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .write_enable (reg_write_enable),
        .write_idx    (reg_write_idx),
        .write_data   (reg_write_data),
        .read_idx_a   (dec.rs),
        .read_idx_b   (dec.rt),
        .read_data_a  (rs_data),
        .read_data_b  (rt_data),
        .register_v0  (register_v0)
    );

    mips_execute execute_i (
        .dec     (dec),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .exec    (exec)
    );

    mips_result result_i (
        .clk              (clk),
        .arst_n           (arst_n),
        .clk_enable       (clk_enable),
        .dec              (dec),
        .exec             (exec),
        .mem_data         (data_readdata),
        .rs_data          (rs_data),
        .pc               (instr_address),
        .active           (active),
        .reg_write_enable (reg_write_enable),
        .reg_write_idx    (reg_write_idx),
        .reg_write_data   (reg_write_data)
    );

    assign data_address   = exec.alu_result;
    assign data_writedata = exec.store_data;
    assign data_read      = dec.mem_read;
    assign data_write     = dec.mem_write;

endmodule

`default_nettype wire

// ==== dv/tb_mips_cpu.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_mips_cpu;

    localparam logic [31:0] rom_base = 32'hBFC00000;
    localparam int clk_period = 40;
    localparam int watchdog_ns = 6 * 300 * clk_period;

    logic        clk;
    logic        arst_n;
    logic        clk_enable;
    logic        active;
    logic [31:0] register_v0;
    logic [31:0] instr_address;
    logic [31:0] instr_readdata;
    logic [31:0] data_address;
    logic        data_write;
    logic        data_read;
    logic [31:0] data_writedata;
    logic [31:0] data_readdata;

    logic [31:0] rom [0:255];
    logic [31:0] ram [0:255];
    logic [31:0] off_rom_word;
    int          prog_len;
    integer      seed = 32'h04104163;

    mips_cpu_harvard dut_i (
        .clk            (clk),
        .arst_n         (arst_n),
        .clk_enable     (clk_enable),
        .active         (active),
        .register_v0    (register_v0),
        .instr_address  (instr_address),
        .instr_readdata (instr_readdata),
        .data_address   (data_address),
        .data_write     (data_write),
        .data_read      (data_read),
        .data_writedata (data_writedata),
        .data_readdata  (data_readdata)
    );

    // Fetches outside the ROM window return off_rom_word
    assign instr_readdata = (instr_address[31:10] == rom_base[31:10]) ?
                            rom[instr_address[9:2]] : off_rom_word;
    assign data_readdata  = ram[data_address[9:2]];

    always @(posedge clk) begin
        if (data_write) begin
            ram[data_address[9:2]] <= data_writedata;
        end
    end

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #(watchdog_ns);
        $display("watchdog expired after %0d ns, the tests did not finish", watchdog_ns);
        stop_on_failure();
    end

    task automatic stop_on_failure();
        $display("TEST FAIL");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    function automatic logic [31:0] rom_addr(input int idx);
        return rom_base + 32'(idx) * 32'd4;
    endfunction

    function automatic logic [31:0] fill_value(input int idx);
        return 32'hDA7A0000 ^ (32'(idx) * 32'h00010001);
    endfunction

    function automatic logic [31:0] rtype(input logic [5:0] fn, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [4:0] rd,
                                          input logic [4:0] sh);
        return {6'h00, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] itype(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] jtype(input logic [5:0] op, input int idx);
        logic [31:0] target;
        target = rom_addr(idx);
        return {op, target[27:2]};
    endfunction

    task automatic emit(input logic [31:0] word);
        rom[prog_len] = word;
        prog_len++;
    endtask

    task automatic start_program();
        prog_len = 0;
        off_rom_word = 32'h0;
        for (int i = 0; i < 256; i++) begin
            rom[i] = 32'h0;
            ram[i] = fill_value(i);
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        arst_n <= 1'b0;
        clk_enable <= 1'b1;
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
    endtask

    task automatic run_program(input string name, input int limit, input bit random_en);
        int          cycles;
        logic        en_at_edge;
        logic [31:0] pc_before;
        logic [31:0] rnd;
        cycles = 0;
        apply_reset();
        @(negedge clk);
        while (active) begin
            pc_before = instr_address;
            @(posedge clk);
            en_at_edge = clk_enable;
            rnd = $random(seed);
            clk_enable <= random_en ? rnd[0] : 1'b1;
            @(negedge clk);
            cycles++;
            assert (en_at_edge || instr_address === pc_before) else begin
                $display("error: %s instr_address moved with clk_enable low, expected %h actual %h",
                         name, pc_before, instr_address);
                stop_on_failure();
            end
            assert (cycles <= limit) else begin
                $display("%s: the core never halted within %0d cycles", name, limit);
                stop_on_failure();
            end
        end
    endtask

    task automatic check_value(input string test, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("error: %s %s expected %h actual %h", test, what, expected, actual);
            stop_on_failure();
        end
    endtask

    task automatic test_register_alu();
        logic [5:0]  functs [0:6] = '{6'h21, 6'h23, 6'h24, 6'h25, 6'h26, 6'h2A, 6'h2B};
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] expected;
        a = 32'h87654321;
        b = 32'h1234ABCD;
        // a is negative, so slt gives 1 while sltu gives 0
        expected = (a + b) + (a - b) + (a & b) + (a | b) + (a ^ b) + 32'd1 + (a << 4) + (a >> 8);
        start_program();
        emit(itype(6'h0F, 0, 8, a[31:16]));
        emit(itype(6'h0D, 8, 8, a[15:0]));
        emit(itype(6'h0F, 0, 9, b[31:16]));
        emit(itype(6'h0D, 9, 9, b[15:0]));
        foreach (functs[i]) begin
            emit(rtype(functs[i], 8, 9, 10, 0));
            emit(rtype(6'h21, 2, 10, 2, 0));
        end
        emit(rtype(6'h00, 0, 8, 10, 4));
        emit(rtype(6'h21, 2, 10, 2, 0));
        emit(rtype(6'h02, 0, 8, 10, 8));
        emit(rtype(6'h21, 2, 10, 2, 0));
        emit(rtype(6'h08, 0, 0, 0, 0));
        run_program("register_alu", 80, 1'b0);
        check_value("register_alu", "v0", expected, register_v0);
    endtask

    task automatic test_immediates();
        logic [31:0] neg5;
        logic [31:0] upper;
        logic [31:0] expected;
        neg5 = 32'hFFFFFFFB;
        upper = 32'hF0F08001;
        // Slti finds zero above -3 and sltiu finds -5 below all ones
        expected = neg5 + 32'd1 + upper + (neg5 & 32'h00008FF0) + (upper ^ 32'h0000FFFF);
        start_program();
        emit(itype(6'h09, 0, 8, 16'hFFFB));
        emit(itype(6'h0A, 0, 9, 16'hFFFD));
        emit(itype(6'h0B, 8, 10, 16'hFFFF));
        emit(itype(6'h0F, 0, 11, 16'hF0F0));
        emit(itype(6'h0D, 11, 11, 16'h8001));
        emit(itype(6'h0C, 8, 12, 16'h8FF0));
        emit(itype(6'h0E, 11, 13, 16'hFFFF));
        for (int r = 8; r < 14; r++) begin
            emit(rtype(6'h21, 2, 5'(r), 2, 0));
        end
        emit(rtype(6'h08, 0, 0, 0, 0));
        run_program("immediates", 80, 1'b0);
        check_value("immediates", "v0", expected, register_v0);
    endtask

    task automatic test_load_store();
        logic [31:0] word_a;
        logic [31:0] word_b;
        logic [31:0] expected;
        word_a = 32'h13579BDF;
        word_b = word_a + word_a;
        expected = word_a + word_b + fill_value(64);
        start_program();
        emit(itype(6'h09, 0, 8, 16'h0040));
        emit(itype(6'h09, 0, 9, 16'h0060));
        emit(itype(6'h0F, 0, 10, 16'h1357));
        emit(itype(6'h0D, 10, 10, 16'h9BDF));
        // Stores land in words 18 and 23 and are read back via the other base
        emit(itype(6'h2B, 8, 10, 16'h0008));
        emit(rtype(6'h21, 10, 10, 11, 0));
        emit(itype(6'h2B, 9, 11, 16'hFFFC));
        emit(itype(6'h23, 9, 12, 16'hFFE8));
        emit(itype(6'h23, 8, 13, 16'h001C));
        emit(itype(6'h23, 0, 14, 16'h0100));
        emit(rtype(6'h21, 12, 13, 2, 0));
        emit(rtype(6'h21, 2, 14, 2, 0));
        emit(rtype(6'h08, 0, 0, 0, 0));
        // Fetch at the halt address is a store over word 18
        off_rom_word = itype(6'h2B, 8, 0, 16'h0008);
        run_program("load_store", 80, 1'b0);
        check_value("load_store", "v0", expected, register_v0);
        check_value("load_store", "ram[23]", word_b, ram[23]);
        repeat (4) begin
            @(negedge clk);
            assert (!data_write && !data_read) else begin
                $display("load_store: a data strobe was driven after the halt");
                stop_on_failure();
            end
        end
        check_value("load_store", "ram[18]", word_a, ram[18]);
    endtask

    task automatic build_branch_program();
        emit(itype(6'h09, 0, 8, 16'h0005));
        emit(itype(6'h09, 0, 2, 16'h0000));
        emit(itype(6'h04, 0, 0, 16'h0001));
        emit(itype(6'h09, 2, 2, 16'h0100));
        // Loop body at index 4
        emit(rtype(6'h21, 2, 8, 2, 0));
        emit(itype(6'h09, 8, 8, 16'hFFFF));
        emit(itype(6'h05, 8, 0, 16'hFFFD));
        emit(itype(6'h04, 8, 2, 16'h0001));
        emit(itype(6'h09, 2, 2, 16'h0020));
        emit(itype(6'h05, 0, 0, 16'h0001));
        emit(itype(6'h09, 2, 2, 16'h0040));
        emit(itype(6'h09, 0, 0, 16'h0055));
        emit(rtype(6'h21, 2, 0, 2, 0));
        emit(rtype(6'h08, 0, 0, 0, 0));
    endtask

    function automatic logic [31:0] branch_total();
        logic [31:0] sum;
        sum = 32'h0;
        for (int n = 5; n > 0; n--) begin
            sum += 32'(n);
        end
        return sum + 32'h20 + 32'h40;
    endfunction

    task automatic test_branches();
        start_program();
        build_branch_program();
        run_program("branches", 80, 1'b0);
        check_value("branches", "v0", branch_total(), register_v0);
    endtask

    task automatic test_jumps();
        logic [31:0] expected;
        expected = 32'd7 + (rom_addr(3) + 32'd4) + (rom_addr(6) + 32'd4);
        start_program();
        emit(itype(6'h09, 0, 2, 16'h0001));
        emit(jtype(6'h02, 3));
        emit(itype(6'h09, 2, 2, 16'h0100));
        emit(jtype(6'h03, 10));
        emit(itype(6'h0F, 0, 9, rom_base[31:16]));
        emit(itype(6'h0D, 9, 9, 16'h0030));
        emit(rtype(6'h09, 9, 0, 10, 0));
        emit(rtype(6'h21, 2, 31, 2, 0));
        emit(rtype(6'h21, 2, 10, 2, 0));
        emit(rtype(6'h08, 0, 0, 0, 0));
        emit(itype(6'h09, 2, 2, 16'h0002));
        emit(rtype(6'h08, 31, 0, 0, 0));
        emit(itype(6'h09, 2, 2, 16'h0004));
        emit(rtype(6'h08, 10, 0, 0, 0));
        run_program("jumps", 80, 1'b0);
        check_value("jumps", "v0", expected, register_v0);
    endtask

    task automatic test_clock_enable();
        start_program();
        build_branch_program();
        run_program("clock_enable", 300, 1'b1);
        check_value("clock_enable", "v0", branch_total(), register_v0);
    endtask

    initial begin
        clk_enable = 1'b0;
        arst_n = 1'b0;
        off_rom_word = 32'h0;
        test_register_alu();
        test_immediates();
        test_load_store();
        test_branches();
        test_jumps();
        test_clock_enable();
        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
rtl/mips_pkg.sv
rtl/mips_decode.sv
rtl/mips_regfile.sv
rtl/mips_execute.sv
rtl/mips_result.sv
rtl/mips_cpu_harvard.sv
dv/tb_mips_cpu.sv
